// ==== Makefile ====
# Verilator build and run for the keypad lock testbench.
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP      = lock_tb
FILELIST = filelist.f
BUILD    = obj_dir
PASS_MSG = Everything OK

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

# The run fails unless the pass message appears as a line of its own.
run: compile
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD)

// ==== filelist.f ====
+incdir+include
source/lock_pkg.sv
source/code_bank.sv
source/code_matcher.sv
source/lock_timer.sv
source/lock_fsm.sv
source/lock_top.sv
test/lock_props.sv
test/lock_tb.sv

// ==== include/lock_defs.svh ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared sizes and timer lengths for the keypad lock.
// Timer lengths are short for simulation and must stay below 2**LOCK_TIMER_W.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef LOCK_DEFS_SVH
`define LOCK_DEFS_SVH

// Entry and code geometry.
`define LOCK_ENTRY_DIGITS 20
`define LOCK_CODE_DIGITS 4
`define LOCK_NUM_CODES 4

// Failures before the lockout.
`define LOCK_MAX_TRIES 5

// Special key digits.
`define LOCK_DIGIT_ERROR 4'hE
`define LOCK_DIGIT_BLANK 4'hF

// Timer lengths in clock cycles.
`define LOCK_DEBOUNCE_CYCLES 8
`define LOCK_RELOCK_CYCLES 40
`define LOCK_BEEP_CYCLES 6
`define LOCK_PENALTY_CYCLES 12
`define LOCK_LOCKOUT_CYCLES 60

`define LOCK_TIMER_W 8

`endif

// ==== source/code_bank.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// User code storage. A slot counts only after its first write.
// Writes show on the outputs one edge after the strobe.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "lock_defs.svh"

module code_bank (
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic                                   code_wr,
  input  lock_pkg::code_sel_t                    code_sel,
  input  lock_pkg::code_t                        code_value,
  output lock_pkg::code_t [`LOCK_NUM_CODES-1:0]  codes,
  output logic [`LOCK_NUM_CODES-1:0]             code_ok
);

  // Valid flags, one per slot.
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      code_ok <= '0;
    end
    else if (code_wr) begin
      code_ok[code_sel] <= 1'b1;
    end
  end

  // Code values themselves.
  always_ff @(posedge clk) begin
    if (code_wr) begin
      codes[code_sel] <= code_value;  // Old value is simply overwritten.
    end
  end

endmodule

// ==== source/code_matcher.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Searches a keyed entry for any valid code at any digit offset.
// Result strobes one cycle after accept; accepts may come every cycle.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "lock_defs.svh"

module code_matcher (
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic                                   accept,
  input  lock_pkg::entry_t                       entry,
  input  lock_pkg::code_t [`LOCK_NUM_CODES-1:0]  codes,
  input  logic [`LOCK_NUM_CODES-1:0]             code_ok,
  output logic                                   match_valid,
  output logic                                   match
);

  lock_pkg::entry_t entry_q;

  // Held entry.
  always_ff @(posedge clk) begin
    if (accept) begin
      entry_q <= entry;
    end
  end

  // Result strobe.
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      match_valid <= 1'b0;
    end
    else begin
      match_valid <= accept;
    end
  end

  // Every window of code length against every written slot.
  // Digit k of the code must sit at digit p+k of the entry.
  always_comb begin
    match = 1'b0;
    for (int c = 0; c < `LOCK_NUM_CODES; c++) begin
      for (int p = 0; p <= `LOCK_ENTRY_DIGITS - `LOCK_CODE_DIGITS; p++) begin
        if (code_ok[c] && (entry_q[p +: `LOCK_CODE_DIGITS] == codes[c])) begin
          match = 1'b1;
        end
      end
    end
  end

endmodule

// ==== source/lock_fsm.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Lock control. Entries are taken only in LOCKED; other strobes drop.
// The inside button acts on release, after a long enough hold.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "lock_defs.svh"

module lock_fsm (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  door_open,
  input  logic                  inside_button,
  input  logic                  entry_valid,
  input  lock_pkg::entry_t      entry,
  input  logic                  match_valid,
  input  logic                  match,
  input  logic                  expired,
  output logic                  accept,
  output logic                  timer_start,
  output lock_pkg::timer_sel_t  timer_sel,
  output logic                  bolt,
  output logic                  beep,
  output logic                  keypad_en,
  output lock_pkg::tries_t      fail_count
);

  lock_pkg::lock_state_t state;
  lock_pkg::lock_state_t state_d;
  lock_pkg::tries_t      fail_d;
  logic                  held;    // Debounce time has passed with the button down.
  logic                  held_d;
  logic                  key_error;
  logic                  key_confirm;

  assign key_error   = entry_valid && (entry[0] == `LOCK_DIGIT_ERROR);
  assign key_confirm = entry_valid && (entry[0] != `LOCK_DIGIT_ERROR) &&
                       (entry[0] != `LOCK_DIGIT_BLANK);

  always_comb begin
    state_d     = state;
    fail_d      = fail_count;
    held_d      = held;
    accept      = 1'b0;
    timer_start = 1'b0;
    timer_sel   = lock_pkg::TMR_DEBOUNCE;
    case (state)
      lock_pkg::STARTUP: begin
        if (!door_open) state_d = lock_pkg::LOCKED;
      end
      lock_pkg::LOCKED: begin
        if (key_error) begin
          state_d     = lock_pkg::BEEP;
          timer_start = 1'b1;
          timer_sel   = lock_pkg::TMR_BEEP;
        end
        else if (key_confirm) begin
          state_d = lock_pkg::VALIDATE;
          accept  = 1'b1;
        end
        else if (inside_button) begin
          state_d     = lock_pkg::DEBOUNCE_UNLOCK;
          timer_start = 1'b1;
          held_d      = 1'b0;
        end
      end
      lock_pkg::VALIDATE: begin
        if (match_valid && match) begin
          state_d     = lock_pkg::UNLOCKED;
          timer_start = 1'b1;
          timer_sel   = lock_pkg::TMR_RELOCK;
        end
        else if (match_valid) begin
          state_d     = lock_pkg::PENALTY;
          fail_d      = fail_count + lock_pkg::tries_t'(1);
          timer_start = 1'b1;
          timer_sel   = lock_pkg::TMR_PENALTY;
        end
      end
      lock_pkg::BEEP: begin
        if (expired) state_d = lock_pkg::LOCKED;
      end
      lock_pkg::PENALTY: begin
        if (expired && (fail_count >= lock_pkg::tries_t'(`LOCK_MAX_TRIES))) begin
          state_d     = lock_pkg::LOCKOUT;
          timer_start = 1'b1;
          timer_sel   = lock_pkg::TMR_LOCKOUT;
        end
        else if (expired) begin
          state_d = lock_pkg::LOCKED;
        end
      end
      lock_pkg::LOCKOUT: begin
        if (expired) begin
          state_d = lock_pkg::LOCKED;
          fail_d  = '0;
        end
      end
      lock_pkg::UNLOCKED: begin
        if (door_open) begin
          state_d = lock_pkg::OPEN;
        end
        else if (inside_button) begin
          state_d     = lock_pkg::DEBOUNCE_LOCK;
          timer_start = 1'b1;
          held_d      = 1'b0;
        end
        else if (expired) begin
          state_d = lock_pkg::LOCKED;  // Auto relock.
          fail_d  = '0;
        end
      end
      lock_pkg::OPEN: begin
        if (!door_open) begin
          state_d     = lock_pkg::UNLOCKED;
          timer_start = 1'b1;
          timer_sel   = lock_pkg::TMR_RELOCK;
        end
      end
      lock_pkg::DEBOUNCE_UNLOCK: begin
        if (!inside_button && (held || expired)) begin
          state_d     = lock_pkg::UNLOCKED;
          timer_start = 1'b1;
          timer_sel   = lock_pkg::TMR_RELOCK;
        end
        else if (!inside_button) begin
          state_d = lock_pkg::LOCKED;  // Too short a press.
        end
        else if (expired) begin
          held_d = 1'b1;
        end
      end
      lock_pkg::DEBOUNCE_LOCK: begin
        if (!inside_button && (held || expired)) begin
          state_d = lock_pkg::LOCKED;
          fail_d  = '0;
        end
        else if (!inside_button) begin
          // Back to UNLOCKED with a fresh relock interval.
          state_d     = lock_pkg::UNLOCKED;
          timer_start = 1'b1;
          timer_sel   = lock_pkg::TMR_RELOCK;
        end
        else if (expired) begin
          held_d = 1'b1;
        end
      end
      default: state_d = lock_pkg::STARTUP;
    endcase
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      state      <= lock_pkg::STARTUP;
      fail_count <= '0;
      held       <= 1'b0;
    end
    else begin
      state      <= state_d;
      fail_count <= fail_d;
      held       <= held_d;
    end
  end

  assign bolt = state inside {lock_pkg::LOCKED, lock_pkg::VALIDATE, lock_pkg::BEEP,
                              lock_pkg::PENALTY, lock_pkg::LOCKOUT,
                              lock_pkg::DEBOUNCE_UNLOCK};
  assign beep      = (state == lock_pkg::BEEP);
  assign keypad_en = (state == lock_pkg::LOCKED);

endmodule

// ==== source/lock_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Types shared by the lock RTL and its testbench.
// Digit 0 of a code or an entry is always the most recent key.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "lock_defs.svh"

package lock_pkg;

  typedef logic [3:0] digit_t;
  typedef digit_t [`LOCK_CODE_DIGITS-1:0] code_t;
  typedef digit_t [`LOCK_ENTRY_DIGITS-1:0] entry_t;  // Unused digits hold the blank value.
  typedef logic [1:0] code_sel_t;
  typedef logic [2:0] tries_t;

  typedef enum logic [3:0] {
    STARTUP,
    LOCKED,
    VALIDATE,
    BEEP,
    PENALTY,
    LOCKOUT,
    UNLOCKED,
    OPEN,
    DEBOUNCE_UNLOCK,
    DEBOUNCE_LOCK
  } lock_state_t;

  typedef enum logic [2:0] {
    TMR_DEBOUNCE,
    TMR_RELOCK,
    TMR_BEEP,
    TMR_PENALTY,
    TMR_LOCKOUT
  } timer_sel_t;

endpackage

// ==== source/lock_timer.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One-shot timer. expired pulses once, the selected length after the
// start cycle. A start while running restarts with the new length.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "lock_defs.svh"

module lock_timer (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  timer_start,
  input  lock_pkg::timer_sel_t  timer_sel,
  output logic                  expired
);

  logic [`LOCK_TIMER_W-1:0] len;
  logic [`LOCK_TIMER_W-1:0] count;
  logic                     running;

  always_comb begin
    case (timer_sel)
      lock_pkg::TMR_DEBOUNCE: len = `LOCK_TIMER_W'(`LOCK_DEBOUNCE_CYCLES);
      lock_pkg::TMR_RELOCK:   len = `LOCK_TIMER_W'(`LOCK_RELOCK_CYCLES);
      lock_pkg::TMR_BEEP:     len = `LOCK_TIMER_W'(`LOCK_BEEP_CYCLES);
      lock_pkg::TMR_PENALTY:  len = `LOCK_TIMER_W'(`LOCK_PENALTY_CYCLES);
      default:                len = `LOCK_TIMER_W'(`LOCK_LOCKOUT_CYCLES);
    endcase
  end

  assign expired = running && (count == '0);  // Last cycle of the interval.

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      running <= 1'b0;
      count   <= '0;
    end
    else if (timer_start) begin
      running <= 1'b1;
      count   <= len - `LOCK_TIMER_W'(1);  // Start cycle counts as the first.
    end
    else if (running) begin
      if (count == '0) begin
        running <= 1'b0;
      end
      else begin
        count <= count - `LOCK_TIMER_W'(1);
      end
    end
  end

endmodule

// ==== source/lock_top.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Keypad door lock. Strobes are single cycle with no back-pressure.
// A confirmed entry resolves one edge after its strobe is sampled.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "lock_defs.svh"

module lock_top (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 door_open,
  input  logic                 inside_button,
  input  lock_pkg::entry_t     entry,
  input  logic                 entry_valid,
  input  logic                 code_wr,
  input  lock_pkg::code_sel_t  code_sel,
  input  lock_pkg::code_t      code_value,
  output logic                 bolt,
  output logic                 beep,
  output logic                 keypad_en,
  output lock_pkg::tries_t     fail_count
);

  lock_pkg::code_t [`LOCK_NUM_CODES-1:0] codes;
  logic [`LOCK_NUM_CODES-1:0]            code_ok;
  logic                                  accept;
  logic                                  match_valid;
  logic                                  match;
  logic                                  timer_start;
  lock_pkg::timer_sel_t                  timer_sel;
  logic                                  expired;

  code_bank u_bank (
    .clk        (clk),
    .rst        (rst),
    .code_wr    (code_wr),
    .code_sel   (code_sel),
    .code_value (code_value),
    .codes      (codes),
    .code_ok    (code_ok)
  );

  code_matcher u_matcher (
    .clk         (clk),
    .rst         (rst),
    .accept      (accept),
    .entry       (entry),
    .codes       (codes),
    .code_ok     (code_ok),
    .match_valid (match_valid),
    .match       (match)
  );

  lock_timer u_timer (
    .clk         (clk),
    .rst         (rst),
    .timer_start (timer_start),
    .timer_sel   (timer_sel),
    .expired     (expired)
  );

  lock_fsm u_fsm (
    .clk           (clk),
    .rst           (rst),
    .door_open     (door_open),
    .inside_button (inside_button),
    .entry_valid   (entry_valid),
    .entry         (entry),
    .match_valid   (match_valid),
    .match         (match),
    .expired       (expired),
    .accept        (accept),
    .timer_start   (timer_start),
    .timer_sel     (timer_sel),
    .bolt          (bolt),
    .beep          (beep),
    .keypad_en     (keypad_en),
    .fail_count    (fail_count)
  );

endmodule

// ==== test/lock_props.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Concurrent checks bound into lock_top; silent while reset is high.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "lock_defs.svh"

module lock_props (
  input logic             clk,
  input logic             rst,
  input logic             bolt,
  input logic             beep,
  input logic             keypad_en,
  input lock_pkg::tries_t fail_count,
  input logic             accept,
  input logic             match_valid
);

  // Keypad only works on a bolted door.
  keypad_bolt: assert property (@(posedge clk) disable iff (rst) keypad_en |-> bolt)
    else $error("keypad enabled while the bolt is retracted");

  accept_result: assert property (@(posedge clk) disable iff (rst) accept |=> match_valid)
    else $error("no match result one cycle after accept");

  result_source: assert property (@(posedge clk) disable iff (rst)
      match_valid |-> $past(accept))
    else $error("match result without an accept one cycle earlier");

  beep_bolt: assert property (@(posedge clk) disable iff (rst) beep |-> bolt)
    else $error("beep while the bolt is retracted");

  tries_limit: assert property (@(posedge clk) disable iff (rst)
      int'(fail_count) <= `LOCK_MAX_TRIES)
    else $error("failed-try count above its limit");

endmodule

bind lock_top lock_props i_props (
  .clk         (clk),
  .rst         (rst),
  .bolt        (bolt),
  .beep        (beep),
  .keypad_en   (keypad_en),
  .fail_count  (fail_count),
  .accept      (accept),
  .match_valid (match_valid)
);

// ==== test/lock_tb.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Self-checking testbench for lock_top; LCG stimulus with a fixed seed.
// Checks sit at fixed cycle offsets from the timing of each transition.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "lock_defs.svh"

module lock_tb;

  localparam int NUM_RANDOM = 24;
  localparam int ENTRY_MAX  = 4 + `LOCK_RELOCK_CYCLES + `LOCK_PENALTY_CYCLES +
                              `LOCK_LOCKOUT_CYCLES;
  // Random entries, the six of the try test, then the button and door tests.
  localparam int RUN_LIMIT  = (NUM_RANDOM + 6) * ENTRY_MAX + 4 * `LOCK_RELOCK_CYCLES + 200;

  logic                clk;
  logic                rst;
  logic                door_open;
  logic                inside_button;
  lock_pkg::entry_t    entry;
  logic                entry_valid;
  logic                code_wr;
  lock_pkg::code_sel_t code_sel;
  lock_pkg::code_t     code_value;
  logic                bolt;
  logic                beep;
  logic                keypad_en;
  lock_pkg::tries_t    fail_count;

  logic [31:0]                rng_state;
  lock_pkg::code_t            model_codes [`LOCK_NUM_CODES];
  logic [`LOCK_NUM_CODES-1:0] model_ok;
  lock_pkg::tries_t           model_tries;
  int                         pass_cnt;
  int                         fail_cnt;
  int                         cycles;

  lock_top i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    cycles = 0;
    while (cycles < RUN_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: tests did not finish within %0d cycles", RUN_LIMIT);
    $display("Something failed");
    $finish;
  end

  function automatic int rand_below(int n);
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return int'(rng_state >> 16) % n;  // Upper bits are the better ones.
  endfunction

  // Keyed digits 0..9 in the low positions, blank digits above them.
  function automatic lock_pkg::entry_t random_entry(logic with_code);
    lock_pkg::entry_t e;
    int len;
    int pos;
    len = `LOCK_CODE_DIGITS + rand_below(`LOCK_ENTRY_DIGITS - `LOCK_CODE_DIGITS + 1);
    for (int i = 0; i < `LOCK_ENTRY_DIGITS; i++) begin
      e[i] = (i < len) ? lock_pkg::digit_t'(rand_below(10)) : `LOCK_DIGIT_BLANK;
    end
    if (with_code) begin
      pos = rand_below(len - `LOCK_CODE_DIGITS + 1);
      e[pos +: `LOCK_CODE_DIGITS] = model_codes[rand_below(`LOCK_NUM_CODES)];
    end
    return e;
  endfunction

  // Any written code, digit by digit, at any start position.
  function automatic logic model_match(lock_pkg::entry_t e);
    logic hit;
    logic same;
    hit = 1'b0;
    for (int c = 0; c < `LOCK_NUM_CODES; c++) begin
      for (int s = 0; s + `LOCK_CODE_DIGITS <= `LOCK_ENTRY_DIGITS; s++) begin
        same = 1'b1;
        for (int k = 0; k < `LOCK_CODE_DIGITS; k++) begin
          if (e[s + k] != model_codes[c][k]) same = 1'b0;
        end
        if (same && model_ok[c]) hit = 1'b1;
      end
    end
    return hit;
  endfunction

  task automatic check_bit(string name, logic expected, logic actual);
    if (expected === actual) begin
      pass_cnt++;
      $display("Pass %s: %b", name, actual);
    end
    else begin
      fail_cnt++;
      $display("Fail %s: expected %b, actual %b", name, expected, actual);
    end
  endtask

  task automatic check_tries(string name, lock_pkg::tries_t expected, lock_pkg::tries_t actual);
    if (expected === actual) begin
      pass_cnt++;
      $display("Pass %s: %0d", name, actual);
    end
    else begin
      fail_cnt++;
      $display("Fail %s: expected %0d, actual %0d", name, expected, actual);
    end
  endtask

  task automatic wait_cycles(int n);
    repeat (n) @(posedge clk);
    @(negedge clk);
  endtask

  task automatic send_entry(lock_pkg::entry_t e);
    entry       = e;
    entry_valid = 1'b1;
    wait_cycles(1);
    entry_valid = 1'b0;
  endtask

  // Confirmed entry with its whole aftermath: relock, or penalty and lockout.
  task automatic try_entry(string name, lock_pkg::entry_t e);
    logic hit;
    hit = model_match(e);
    send_entry(e);
    wait_cycles(1);
    check_bit({name, " bolt"}, !hit, bolt);
    if (hit) begin
      wait_cycles(`LOCK_RELOCK_CYCLES - 1);
      check_bit({name, " still unlocked"}, 1'b0, bolt);
      wait_cycles(1);
      model_tries = '0;
      check_bit({name, " relocked"}, 1'b1, keypad_en);
      check_tries({name, " tries cleared"}, model_tries, fail_count);
    end
    else begin
      model_tries = model_tries + lock_pkg::tries_t'(1);
      check_tries({name, " tries"}, model_tries, fail_count);
      wait_cycles(`LOCK_PENALTY_CYCLES - 1);
      check_bit({name, " penalty"}, 1'b0, keypad_en);
      wait_cycles(1);
      if (int'(model_tries) >= `LOCK_MAX_TRIES) begin
        check_bit({name, " lockout"}, 1'b0, keypad_en);
        wait_cycles(`LOCK_LOCKOUT_CYCLES - 1);
        check_bit({name, " lockout held"}, 1'b0, keypad_en);
        wait_cycles(1);
        model_tries = '0;
        check_tries({name, " lockout cleared"}, model_tries, fail_count);
      end
      check_bit({name, " keypad back"}, 1'b1, keypad_en);
    end
  endtask

  task automatic press_button(int len);
    inside_button = 1'b1;
    wait_cycles(len);
    inside_button = 1'b0;
  endtask

  initial begin
    lock_pkg::entry_t e;
    rng_state     = 32'h89a1;
    pass_cnt      = 0;
    fail_cnt      = 0;
    model_ok      = '0;
    model_tries   = '0;
    rst           = 1'b1;
    door_open     = 1'b0;
    inside_button = 1'b0;
    entry         = '0;
    entry_valid   = 1'b0;
    code_wr       = 1'b0;
    code_sel      = '0;
    code_value    = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    check_bit("reset bolt", 1'b0, bolt);
    check_bit("reset beep", 1'b0, beep);
    check_bit("reset keypad", 1'b0, keypad_en);
    rst = 1'b0;
    wait_cycles(1);
    check_bit("startup bolt", 1'b1, bolt);
    check_bit("startup keypad", 1'b1, keypad_en);
    check_tries("startup tries", model_tries, fail_count);

    for (int s = 0; s < `LOCK_NUM_CODES; s++) begin
      for (int k = 0; k < `LOCK_CODE_DIGITS; k++) begin
        code_value[k] = lock_pkg::digit_t'(rand_below(10));
      end
      code_sel       = lock_pkg::code_sel_t'(s);
      code_wr        = 1'b1;
      model_codes[s] = code_value;
      model_ok[s]    = 1'b1;
      wait_cycles(1);
    end
    code_wr = 1'b0;

    for (int i = 0; i < NUM_RANDOM; i++) begin
      try_entry($sformatf("random %0d", i), random_entry(rand_below(2) == 1));
    end

    e    = random_entry(1'b0);
    e[0] = `LOCK_DIGIT_ERROR;
    send_entry(e);
    check_bit("abort beep", 1'b1, beep);
    check_bit("abort bolt", 1'b1, bolt);
    wait_cycles(`LOCK_BEEP_CYCLES - 1);
    check_bit("abort beep held", 1'b1, beep);
    wait_cycles(1);
    check_bit("abort beep off", 1'b0, beep);
    check_bit("abort keypad", 1'b1, keypad_en);

    try_entry("clear tries", random_entry(1'b1));
    for (int i = 1; i <= `LOCK_MAX_TRIES; i++) begin
      do begin
        e = random_entry(1'b0);
      end while (model_match(e));
      try_entry($sformatf("wrong %0d", i), e);
    end

    press_button(`LOCK_DEBOUNCE_CYCLES - 1);
    check_bit("short press bolt", 1'b1, bolt);
    wait_cycles(1);
    check_bit("short press locked", 1'b1, keypad_en);
    press_button(`LOCK_DEBOUNCE_CYCLES);
    wait_cycles(1);
    check_bit("button unlock", 1'b0, bolt);
    press_button(`LOCK_DEBOUNCE_CYCLES + 4);
    check_bit("lock press bolt", 1'b0, bolt);
    wait_cycles(1);
    check_bit("button lock", 1'b1, keypad_en);
    check_tries("button lock tries", model_tries, fail_count);

    press_button(`LOCK_DEBOUNCE_CYCLES);
    wait_cycles(10);
    door_open = 1'b1;
    wait_cycles(1);
    check_bit("door open bolt", 1'b0, bolt);
    wait_cycles(`LOCK_RELOCK_CYCLES + 10);
    check_bit("door held open", 1'b0, bolt);
    door_open = 1'b0;
    wait_cycles(`LOCK_RELOCK_CYCLES);
    check_bit("relock restarted", 1'b0, bolt);
    wait_cycles(1);
    check_bit("relock after close", 1'b1, bolt);

    $display("Checks passed: %0d, failed: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("Everything OK");
    end
    else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule
